// File: all.f
+incdir+hdl
hdl/dcache_pkg.sv
hdl/dcache_tag_array.sv
hdl/dcache_data_array.sv
hdl/dcache_store_mask.sv
hdl/dcache_ctrl.sv
hdl/dcache_perf_counters.sv
hdl/dcache_top.sv
verif/dcache_mem_model.sv
verif/dcache_tb.sv

// File: hdl/dcache_cfg.svh
/*
 * Geometry and width settings of the L1 data cache.
 * Include this wherever the address split or array sizes are needed.
 */

`ifndef DCACHE_CFG_SVH
`define DCACHE_CFG_SVH

// ==========================================================================
// Address and data width
// ==========================================================================
`define DC_ADDR_BITS    32

// ==========================================================================
// Cache geometry
// ==========================================================================
// 64 lines of 16 bytes, direct mapped
`define DC_INDEX_BITS   6
`define DC_LINES        64
`define DC_OFFSET_BITS  4
`define DC_TAG_BITS     22
`define DC_WORDS        4
`define DC_LINE_BITS    128

// Performance counter width
`define DC_CNT_BITS     32

`endif

// File: hdl/dcache_ctrl.sv
/*
 * Control for the direct-mapped write-through data cache.
 * Accepts core requests in idle, looks up the tag, refills lines on
 * read misses, forwards every store to memory and raises one pulse per
 * completed access for the performance counters.
 */

`include "dcache_cfg.svh"

module dcache_ctrl (
  input  logic                        clk,
  input  logic                        rstn,
  // Core side
  input  logic                        core_req,
  input  logic [`DC_ADDR_BITS-1:0]    core_addr,
  input  logic                        core_write,
  input  dcache_pkg::dcache_size_e    core_size,
  input  logic [`DC_ADDR_BITS-1:0]    core_wdata,
  output logic                        core_wait,
  output logic [`DC_ADDR_BITS-1:0]    core_rdata,
  // Arrays
  output logic [`DC_INDEX_BITS-1:0]   index,
  output logic                        tag_wen,
  output logic [`DC_TAG_BITS-1:0]     tag_wdata,
  input  logic [`DC_TAG_BITS-1:0]     tag_rdata,
  output logic [`DC_LINE_BITS/8-1:0]  byte_wen,
  output dcache_pkg::dcache_line_u    line_wdata,
  input  dcache_pkg::dcache_line_u    line_rdata,
  input  logic [`DC_LINE_BITS/8-1:0]  store_en,
  input  dcache_pkg::dcache_line_u    store_line,
  // Memory side
  output logic                        mem_req,
  output logic                        mem_write,
  output logic [`DC_ADDR_BITS-1:0]    mem_addr,
  output dcache_pkg::dcache_size_e    mem_size,
  output logic [`DC_ADDR_BITS-1:0]    mem_wdata,
  input  logic                        mem_done,
  input  logic [`DC_ADDR_BITS-1:0]    mem_rdata,
  // Event pulses
  output logic                        read_hit_pulse,
  output logic                        write_hit_pulse,
  output logic                        read_miss_pulse,
  output logic                        write_miss_pulse
);

  localparam int unsigned BEAT_BITS = $clog2(`DC_WORDS);

  dcache_pkg::dcache_state_e state, state_next;

  logic [`DC_ADDR_BITS-1:0]   req_addr;
  logic                       req_write;
  dcache_pkg::dcache_size_e   req_size;
  logic [`DC_ADDR_BITS-1:0]   req_wdata;
  logic [`DC_INDEX_BITS-1:0]  core_index;
  logic [`DC_INDEX_BITS-1:0]  req_index;
  logic [`DC_TAG_BITS-1:0]    req_tag;
  logic [1:0]                 req_word;

  logic [`DC_LINES-1:0]       valid;
  logic [BEAT_BITS-1:0]       beat_cnt;
  logic                       req_sent;
  logic                       mem_active;
  logic                       tag_hit;
  logic                       last_beat;
  dcache_pkg::dcache_line_u   refill_buf;
  dcache_pkg::dcache_line_u   refill_line;

  // ========================================================================
  // Request capture and address split
  // ========================================================================
  always_ff @(posedge clk) begin
    if (state == dcache_pkg::st_idle) begin
      req_addr  <= core_addr;
      req_write <= core_write;
      req_size  <= core_size;
      req_wdata <= core_wdata;
    end
  end

  assign core_index = core_addr[`DC_OFFSET_BITS +: `DC_INDEX_BITS];
  assign req_index  = req_addr[`DC_OFFSET_BITS +: `DC_INDEX_BITS];
  assign req_tag    = req_addr[`DC_ADDR_BITS-1 -: `DC_TAG_BITS];
  assign req_word   = req_addr[`DC_OFFSET_BITS-1:2];

  // Arrays are read at acceptance with the incoming address
  assign index = (state == dcache_pkg::st_idle) ? core_index : req_index;

  // ========================================================================
  // State machine
  // ========================================================================
  assign tag_hit   = (tag_rdata == req_tag);
  assign last_beat = (state == dcache_pkg::st_read_miss) && mem_done &&
                     (beat_cnt == BEAT_BITS'(`DC_WORDS - 1));

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      state <= dcache_pkg::st_idle;
    end else begin
      state <= state_next;
    end
  end

  always_comb begin
    state_next = state;
    case (state)
      dcache_pkg::st_idle: begin
        if (core_req) begin
          // An invalid line cannot hit, so skip the tag check
          if (!valid[core_index]) begin
            state_next = core_write ? dcache_pkg::st_write_miss : dcache_pkg::st_read_miss;
          end else begin
            state_next = dcache_pkg::st_check;
          end
        end
      end
      dcache_pkg::st_check: begin
        if (req_write) begin
          state_next = tag_hit ? dcache_pkg::st_write_hit : dcache_pkg::st_write_miss;
        end else begin
          state_next = tag_hit ? dcache_pkg::st_idle : dcache_pkg::st_read_miss;
        end
      end
      dcache_pkg::st_write_hit,
      dcache_pkg::st_write_miss: begin
        if (mem_done) begin
          state_next = dcache_pkg::st_idle;
        end
      end
      dcache_pkg::st_read_miss: begin
        if (last_beat) begin
          state_next = dcache_pkg::st_idle;
        end
      end
      default: state_next = dcache_pkg::st_idle;
    endcase
  end

  // Valid bits, beat count and request-issued flag
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      valid    <= '0;
      beat_cnt <= '0;
      req_sent <= 1'b0;
    end else begin
      if (last_beat) begin
        valid[req_index] <= 1'b1;
      end
      if (state == dcache_pkg::st_idle) begin
        beat_cnt <= '0;
        req_sent <= 1'b0;
      end else begin
        if (state == dcache_pkg::st_read_miss && mem_done) begin
          beat_cnt <= beat_cnt + 1'b1;
        end
        if (mem_req) begin
          req_sent <= 1'b1;
        end
      end
    end
  end

  // ========================================================================
  // Refill buffer
  // ========================================================================
  // Beats arrive in ascending order and shift down from the top word
  assign refill_line = {mem_rdata, refill_buf.words[`DC_WORDS-1:1]};

  always_ff @(posedge clk) begin
    if (state == dcache_pkg::st_read_miss && mem_done) begin
      refill_buf <= refill_line;
    end
  end

  // ========================================================================
  // Array writes and core response
  // ========================================================================
  assign tag_wen   = last_beat;
  assign tag_wdata = req_tag;

  always_comb begin
    byte_wen   = '0;
    line_wdata = refill_line;
    if (last_beat) begin
      byte_wen = '1;
    end else if (write_hit_pulse) begin
      byte_wen   = store_en;
      line_wdata = store_line;
    end
  end

  assign core_wait = (state != dcache_pkg::st_idle);

  always_ff @(posedge clk) begin
    if (read_hit_pulse) begin
      core_rdata <= line_rdata.words[req_word];
    end else if (last_beat) begin
      core_rdata <= refill_line.words[req_word];
    end
  end

  // ========================================================================
  // Memory port
  // ========================================================================
  assign mem_active = (state == dcache_pkg::st_write_hit) ||
                      (state == dcache_pkg::st_write_miss) ||
                      (state == dcache_pkg::st_read_miss);
  assign mem_req    = mem_active && !req_sent;
  assign mem_write  = (state == dcache_pkg::st_write_hit) ||
                      (state == dcache_pkg::st_write_miss);
  // Refills fetch the whole line as words
  assign mem_addr   = (state == dcache_pkg::st_read_miss) ?
                      {req_addr[`DC_ADDR_BITS-1:`DC_OFFSET_BITS], {`DC_OFFSET_BITS{1'b0}}} :
                      req_addr;
  assign mem_size   = (state == dcache_pkg::st_read_miss) ? dcache_pkg::size_word : req_size;
  assign mem_wdata  = req_wdata;

  // Event pulses
  assign read_hit_pulse   = (state == dcache_pkg::st_check) && tag_hit && !req_write;
  assign write_hit_pulse  = (state == dcache_pkg::st_write_hit) && mem_done;
  assign read_miss_pulse  = last_beat;
  assign write_miss_pulse = (state == dcache_pkg::st_write_miss) && mem_done;

endmodule

// File: hdl/dcache_data_array.sv
/*
 * Line memory of the data cache.
 * Any subset of the 16 bytes of a line can be written in one cycle.
 * With no byte enabled the port reads, and line_rdata follows one
 * cycle after the index.
 */

`include "dcache_cfg.svh"

module dcache_data_array (
  input  logic                        clk,
  input  logic [`DC_INDEX_BITS-1:0]   index,
  input  logic [`DC_LINE_BITS/8-1:0]  byte_wen,
  input  dcache_pkg::dcache_line_u    line_wdata,
  output dcache_pkg::dcache_line_u    line_rdata
);

  dcache_pkg::dcache_line_u lines [`DC_LINES];

  // ========================================================================
  // Byte-merging write
  // ========================================================================
  always_ff @(posedge clk) begin
    for (int i = 0; i < `DC_LINE_BITS / 8; i++) begin
      if (byte_wen[i]) begin
        lines[index].bytes[i] <= line_wdata.bytes[i];
      end
    end
  end

  // ========================================================================
  // Registered read
  // ========================================================================
  always_ff @(posedge clk) begin
    if (byte_wen == '0) begin
      line_rdata <= lines[index];
    end
  end

endmodule

// File: hdl/dcache_perf_counters.sv
/*
 * Hit and miss counters of the data cache.
 * Each counter adds one per pulse and wraps around.
 */

`include "dcache_cfg.svh"

module dcache_perf_counters (
  input  logic                     clk,
  input  logic                     rstn,
  input  logic                     read_hit_pulse,
  input  logic                     write_hit_pulse,
  input  logic                     read_miss_pulse,
  input  logic                     write_miss_pulse,
  output logic [`DC_CNT_BITS-1:0]  read_hits,
  output logic [`DC_CNT_BITS-1:0]  write_hits,
  output logic [`DC_CNT_BITS-1:0]  read_misses,
  output logic [`DC_CNT_BITS-1:0]  write_misses
);

  logic [3:0]               pulse;
  logic [`DC_CNT_BITS-1:0]  count [4];

  assign pulse = {write_miss_pulse, read_miss_pulse, write_hit_pulse, read_hit_pulse};

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      for (int i = 0; i < 4; i++) begin
        count[i] <= '0;
      end
    end else begin
      for (int i = 0; i < 4; i++) begin
        if (pulse[i]) begin
          count[i] <= count[i] + 1'b1;
        end
      end
    end
  end

  assign read_hits    = count[0];
  assign write_hits   = count[1];
  assign read_misses  = count[2];
  assign write_misses = count[3];

endmodule

// File: hdl/dcache_pkg.sv
/*
 * Types shared by the data cache blocks and the testbench.
 * Compile before any file that refers to dcache_pkg.
 */

`include "dcache_cfg.svh"

package dcache_pkg;

  // Access size on the core and memory sides
  typedef enum logic [1:0] {
    size_byte = 2'd0,
    size_half = 2'd1,
    size_word = 2'd2
  } dcache_size_e;

  // Controller states
  typedef enum logic [2:0] {
    st_idle       = 3'd0,
    st_check      = 3'd1,
    st_write_hit  = 3'd2,
    st_write_miss = 3'd3,
    st_read_miss  = 3'd4
  } dcache_state_e;

  // One cache line, seen as words or as bytes
  typedef union packed {
    logic [`DC_WORDS-1:0][`DC_ADDR_BITS-1:0] words;
    logic [`DC_LINE_BITS/8-1:0][7:0]          bytes;
  } dcache_line_u;

endpackage

// File: hdl/dcache_store_mask.sv
/*
 * Store merge helper.
 * Turns the byte offset, size and data of a store into byte enables
 * over a whole line, with the store data copied into every lane so the
 * enabled bytes pick up the right value.
 */

`include "dcache_cfg.svh"

module dcache_store_mask (
  input  logic [`DC_OFFSET_BITS-1:0]  offset,
  input  dcache_pkg::dcache_size_e    size,
  input  logic [`DC_ADDR_BITS-1:0]    wdata,
  output logic [`DC_LINE_BITS/8-1:0]  byte_en,
  output dcache_pkg::dcache_line_u    line_data
);

  logic [1:0] word_sel;
  logic [1:0] byte_sel;
  logic [3:0] lane_en;

  assign word_sel = offset[`DC_OFFSET_BITS-1:2];
  assign byte_sel = offset[1:0];

  // Lanes inside the addressed word
  always_comb begin
    case (size)
      dcache_pkg::size_byte: lane_en = 4'b0001 << byte_sel;
      // Half stores are forced to an even byte
      dcache_pkg::size_half: lane_en = 4'b0011 << {byte_sel[1], 1'b0};
      default:               lane_en = 4'b1111;
    endcase
  end

  // Move the lanes to the addressed word
  assign byte_en = {{(`DC_LINE_BITS / 8 - 4){1'b0}}, lane_en} << {word_sel, 2'b00};

  // Replicate the low part of the store data over the line
  always_comb begin
    case (size)
      dcache_pkg::size_byte: begin
        for (int i = 0; i < `DC_LINE_BITS / 8; i++) begin
          line_data.bytes[i] = wdata[7:0];
        end
      end
      dcache_pkg::size_half: line_data = {(`DC_LINE_BITS / 16){wdata[15:0]}};
      default:               line_data = {`DC_WORDS{wdata}};
    endcase
  end

endmodule

// File: hdl/dcache_tag_array.sv
/*
 * Tag memory of the data cache, one tag per line.
 * Single port: a write when tag_wen is high, otherwise a read whose
 * result appears on tag_rdata one cycle later.
 */

`include "dcache_cfg.svh"

module dcache_tag_array (
  input  logic                      clk,
  input  logic [`DC_INDEX_BITS-1:0] index,
  input  logic                      tag_wen,
  input  logic [`DC_TAG_BITS-1:0]   tag_wdata,
  output logic [`DC_TAG_BITS-1:0]   tag_rdata
);

  logic [`DC_TAG_BITS-1:0] tags [`DC_LINES];

  // Read and write share the port
  always_ff @(posedge clk) begin
    if (tag_wen) begin
      tags[index] <= tag_wdata;
    end else begin
      tag_rdata <= tags[index];
    end
  end

endmodule

// File: hdl/dcache_top.sv
/*
 * Top level of the L1 data cache.
 * Core ports on one side, the line refill and store port towards memory
 * on the other, and the four event counters for observation.
 */

`include "dcache_cfg.svh"

module dcache_top (
  input  logic                      clk,
  input  logic                      rstn,
  // Core side
  input  logic                      core_req,
  input  logic [`DC_ADDR_BITS-1:0]  core_addr,
  input  logic                      core_write,
  input  dcache_pkg::dcache_size_e  core_size,
  input  logic [`DC_ADDR_BITS-1:0]  core_wdata,
  output logic                      core_wait,
  output logic [`DC_ADDR_BITS-1:0]  core_rdata,
  // Memory side
  output logic                      mem_req,
  output logic                      mem_write,
  output logic [`DC_ADDR_BITS-1:0]  mem_addr,
  output dcache_pkg::dcache_size_e  mem_size,
  output logic [`DC_ADDR_BITS-1:0]  mem_wdata,
  input  logic                      mem_done,
  input  logic [`DC_ADDR_BITS-1:0]  mem_rdata,
  // Counters
  output logic [`DC_CNT_BITS-1:0]   read_hits,
  output logic [`DC_CNT_BITS-1:0]   write_hits,
  output logic [`DC_CNT_BITS-1:0]   read_misses,
  output logic [`DC_CNT_BITS-1:0]   write_misses
);

  logic [`DC_INDEX_BITS-1:0]   index;
  logic                        tag_wen;
  logic [`DC_TAG_BITS-1:0]     tag_wdata;
  logic [`DC_TAG_BITS-1:0]     tag_rdata;
  logic [`DC_LINE_BITS/8-1:0]  byte_wen;
  dcache_pkg::dcache_line_u    line_wdata;
  dcache_pkg::dcache_line_u    line_rdata;
  logic [`DC_LINE_BITS/8-1:0]  store_en;
  dcache_pkg::dcache_line_u    store_line;
  logic                        read_hit_pulse;
  logic                        write_hit_pulse;
  logic                        read_miss_pulse;
  logic                        write_miss_pulse;

  dcache_ctrl u_ctrl (
    .clk              (clk),
    .rstn             (rstn),
    .core_req         (core_req),
    .core_addr        (core_addr),
    .core_write       (core_write),
    .core_size        (core_size),
    .core_wdata       (core_wdata),
    .core_wait        (core_wait),
    .core_rdata       (core_rdata),
    .index            (index),
    .tag_wen          (tag_wen),
    .tag_wdata        (tag_wdata),
    .tag_rdata        (tag_rdata),
    .byte_wen         (byte_wen),
    .line_wdata       (line_wdata),
    .line_rdata       (line_rdata),
    .store_en         (store_en),
    .store_line       (store_line),
    .mem_req          (mem_req),
    .mem_write        (mem_write),
    .mem_addr         (mem_addr),
    .mem_size         (mem_size),
    .mem_wdata        (mem_wdata),
    .mem_done         (mem_done),
    .mem_rdata        (mem_rdata),
    .read_hit_pulse   (read_hit_pulse),
    .write_hit_pulse  (write_hit_pulse),
    .read_miss_pulse  (read_miss_pulse),
    .write_miss_pulse (write_miss_pulse)
  );

  dcache_tag_array u_tag_array (
    .clk       (clk),
    .index     (index),
    .tag_wen   (tag_wen),
    .tag_wdata (tag_wdata),
    .tag_rdata (tag_rdata)
  );

  dcache_data_array u_data_array (
    .clk        (clk),
    .index      (index),
    .byte_wen   (byte_wen),
    .line_wdata (line_wdata),
    .line_rdata (line_rdata)
  );

  // Store fields come from the registered request on the memory port
  dcache_store_mask u_store_mask (
    .offset    (mem_addr[`DC_OFFSET_BITS-1:0]),
    .size      (mem_size),
    .wdata     (mem_wdata),
    .byte_en   (store_en),
    .line_data (store_line)
  );

  dcache_perf_counters u_perf_counters (
    .clk              (clk),
    .rstn             (rstn),
    .read_hit_pulse   (read_hit_pulse),
    .write_hit_pulse  (write_hit_pulse),
    .read_miss_pulse  (read_miss_pulse),
    .write_miss_pulse (write_miss_pulse),
    .read_hits        (read_hits),
    .write_hits       (write_hits),
    .read_misses      (read_misses),
    .write_misses     (write_misses)
  );

endmodule

// File: verif/dcache_mem_model.sv
/*
 * Behavioral word memory behind the data cache in the testbench.
 * Serves one transaction per mem_req: four read beats or one write.
 * A done pulse is held back in every cycle where stall is high.
 */

`include "dcache_cfg.svh"

module dcache_mem_model #(
  parameter int unsigned MEM_WORDS = 4096
) (
  input  logic                      clk,
  input  logic                      stall,
  input  logic                      mem_req,
  input  logic                      mem_write,
  input  logic [`DC_ADDR_BITS-1:0]  mem_addr,
  input  dcache_pkg::dcache_size_e  mem_size,
  input  logic [`DC_ADDR_BITS-1:0]  mem_wdata,
  output logic                      mem_done,
  output logic [`DC_ADDR_BITS-1:0]  mem_rdata
);

  localparam int unsigned WADDR_BITS = $clog2(MEM_WORDS);

  logic [`DC_ADDR_BITS-1:0] words [MEM_WORDS];

  // Transaction record, read by the testbench
  int unsigned              read_beats;
  int unsigned              write_count;
  logic [`DC_ADDR_BITS-1:0] last_rd_addr;
  dcache_pkg::dcache_size_e last_rd_size;
  logic [`DC_ADDR_BITS-1:0] last_wr_addr;
  dcache_pkg::dcache_size_e last_wr_size;

  // Store data sits in the low lanes of mem_wdata
  function automatic logic [31:0] store_lanes(input logic [31:0] old, input logic [1:0] lane,
                                              input dcache_pkg::dcache_size_e size,
                                              input logic [31:0] data);
    logic [31:0] res;
    res = old;
    case (size)
      dcache_pkg::size_byte: res[{lane, 3'b000} +: 8] = data[7:0];
      dcache_pkg::size_half: res[{lane[1], 4'b0000} +: 16] = data[15:0];
      default:               res = data;
    endcase
    return res;
  endfunction

  task automatic serve_request();
    logic                     is_write;
    logic [`DC_ADDR_BITS-1:0] addr;
    dcache_pkg::dcache_size_e size;
    logic [`DC_ADDR_BITS-1:0] wdata;
    logic [WADDR_BITS-1:0]    waddr;
    logic                     stalled;
    int                       beats;
    int                       b;
    is_write = mem_write;
    addr     = mem_addr;
    size     = mem_size;
    wdata    = mem_wdata;
    beats    = is_write ? 1 : `DC_WORDS;
    if (is_write) begin
      last_wr_addr = addr;
      last_wr_size = size;
    end else begin
      last_rd_addr = addr;
      last_rd_size = size;
    end
    b = 0;
    while (b < beats) begin
      stalled = stall;
      #1;
      mem_done = !stalled;
      if (!stalled) begin
        waddr = addr[WADDR_BITS+1:2] + b;
        if (is_write) begin
          words[waddr] = store_lanes(words[waddr], addr[1:0], size, wdata);
          write_count++;
        end else begin
          mem_rdata = words[waddr];
          read_beats++;
        end
        b++;
      end
      @(posedge clk);
    end
    #1;
    mem_done = 1'b0;
  endtask

  initial begin
    mem_done    = 1'b0;
    mem_rdata   = '0;
    read_beats  = 0;
    write_count = 0;
    forever begin
      @(posedge clk);
      if (mem_req) begin
        serve_request();
      end
    end
  end

endmodule

// File: verif/dcache_tb.sv
/*
 * Directed testbench of the data cache.
 * Keeps a reference memory and a shadow of valid bits and tags, predicts
 * hit or miss for every access and checks data, memory traffic and counters.
 */

`include "dcache_cfg.svh"

module dcache_tb;

  localparam int NUM_OPS   = 219;
  localparam int OP_BOUND  = 400;
  localparam int MEM_WORDS = 4096;

  logic                      clk;
  logic                      rstn;
  logic                      core_req;
  logic [`DC_ADDR_BITS-1:0]  core_addr;
  logic                      core_write;
  dcache_pkg::dcache_size_e  core_size;
  logic [`DC_ADDR_BITS-1:0]  core_wdata;
  logic                      core_wait;
  logic [`DC_ADDR_BITS-1:0]  core_rdata;
  logic                      mem_req;
  logic                      mem_write;
  logic [`DC_ADDR_BITS-1:0]  mem_addr;
  dcache_pkg::dcache_size_e  mem_size;
  logic [`DC_ADDR_BITS-1:0]  mem_wdata;
  logic                      mem_done;
  logic [`DC_ADDR_BITS-1:0]  mem_rdata;
  logic [`DC_CNT_BITS-1:0]   read_hits;
  logic [`DC_CNT_BITS-1:0]   write_hits;
  logic [`DC_CNT_BITS-1:0]   read_misses;
  logic [`DC_CNT_BITS-1:0]   write_misses;
  logic                      stall;

  // Reference state
  logic [31:0]               ref_mem [MEM_WORDS];
  logic                      shadow_valid [`DC_LINES];
  logic [`DC_TAG_BITS-1:0]   shadow_tag [`DC_LINES];
  int unsigned               exp_rh;
  int unsigned               exp_wh;
  int unsigned               exp_rm;
  int unsigned               exp_wm;
  logic [31:0]               op_rng;
  logic [31:0]               stall_rng;

  dcache_top u_dut (
    .clk          (clk),
    .rstn         (rstn),
    .core_req     (core_req),
    .core_addr    (core_addr),
    .core_write   (core_write),
    .core_size    (core_size),
    .core_wdata   (core_wdata),
    .core_wait    (core_wait),
    .core_rdata   (core_rdata),
    .mem_req      (mem_req),
    .mem_write    (mem_write),
    .mem_addr     (mem_addr),
    .mem_size     (mem_size),
    .mem_wdata    (mem_wdata),
    .mem_done     (mem_done),
    .mem_rdata    (mem_rdata),
    .read_hits    (read_hits),
    .write_hits   (write_hits),
    .read_misses  (read_misses),
    .write_misses (write_misses)
  );

  dcache_mem_model #(.MEM_WORDS(MEM_WORDS)) u_mem (
    .clk       (clk),
    .stall     (stall),
    .mem_req   (mem_req),
    .mem_write (mem_write),
    .mem_addr  (mem_addr),
    .mem_size  (mem_size),
    .mem_wdata (mem_wdata),
    .mem_done  (mem_done),
    .mem_rdata (mem_rdata)
  );

  // ==========================================================================
  // Helpers
  // ==========================================================================
  function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic logic [31:0] fill_word(input logic [31:0] addr);
    return {addr[15:0] ^ addr[31:16] ^ 16'h3c5a, ~addr[15:0]};
  endfunction

  function automatic logic [31:0] merge_store(input logic [31:0] old, input logic [1:0] lane,
                                              input dcache_pkg::dcache_size_e size,
                                              input logic [31:0] data);
    logic [31:0] res;
    res = old;
    if (size == dcache_pkg::size_byte) begin
      res[lane*8 +: 8] = data[7:0];
    end else if (size == dcache_pkg::size_half) begin
      res[lane[1]*16 +: 16] = data[15:0];
    end else begin
      res = data;
    end
    return res;
  endfunction

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("ERRORS FOUND");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
      abort_run($sformatf("ERROR %s: got 0x%h, expected 0x%h", name, got, exp));
    end
  endtask

  task automatic check_true(input logic cond, input string what);
    assert (cond === 1'b1) else begin
      abort_run(what);
    end
  endtask

  // One access, started a short delay after a rising edge
  task automatic run_access(input logic write, input logic [31:0] addr,
                            input dcache_pkg::dcache_size_e size, input logic [31:0] wdata);
    logic [`DC_INDEX_BITS-1:0] idx;
    logic [`DC_TAG_BITS-1:0]   tag;
    logic                      hit;
    int                        widx;
    int                        cycles;
    int unsigned               beats_before;
    int unsigned               writes_before;
    idx           = addr[`DC_OFFSET_BITS +: `DC_INDEX_BITS];
    tag           = addr[31 -: `DC_TAG_BITS];
    widx          = addr[13:2];
    hit           = shadow_valid[idx] && (shadow_tag[idx] == tag);
    beats_before  = u_mem.read_beats;
    writes_before = u_mem.write_count;
    core_req   = 1'b1;
    core_addr  = addr;
    core_write = write;
    core_size  = size;
    core_wdata = wdata;
    @(posedge clk);
    #1;
    core_req = 1'b0;
    check_true(core_wait, "core_wait did not rise after the request was accepted");
    cycles = 0;
    while (core_wait) begin
      @(posedge clk);
      #1;
      cycles++;
    end
    if (write) begin
      ref_mem[widx] = merge_store(ref_mem[widx], addr[1:0], size, wdata);
      if (hit) exp_wh++;
      else exp_wm++;
      check_value("mem write count", u_mem.write_count, writes_before + 1);
      check_value("mem_addr", u_mem.last_wr_addr, addr);
      check_value("mem_size", u_mem.last_wr_size, size);
      check_value("memory word", u_mem.words[widx], ref_mem[widx]);
      check_value("mem read beats", u_mem.read_beats, beats_before);
    end else begin
      if (hit) begin
        exp_rh++;
        check_value("read hit wait cycles", cycles, 1);
        check_value("mem read beats", u_mem.read_beats, beats_before);
      end else begin
        exp_rm++;
        shadow_valid[idx] = 1'b1;
        shadow_tag[idx]   = tag;
        check_value("mem read beats", u_mem.read_beats, beats_before + `DC_WORDS);
        check_value("refill mem_addr", u_mem.last_rd_addr, {addr[31:4], 4'h0});
        check_value("refill mem_size", u_mem.last_rd_size, dcache_pkg::size_word);
      end
      check_value("core_rdata", core_rdata, ref_mem[widx]);
    end
    check_value("read_hits", read_hits, exp_rh);
    check_value("write_hits", write_hits, exp_wh);
    check_value("read_misses", read_misses, exp_rm);
    check_value("write_misses", write_misses, exp_wm);
  endtask

  // ==========================================================================
  // Tests
  // ==========================================================================
  task automatic cold_miss_then_hit();
    run_access(1'b0, 32'h0000_0104, dcache_pkg::size_word, 32'h0);
    run_access(1'b0, 32'h0000_0108, dcache_pkg::size_word, 32'h0);
  endtask

  task automatic partial_stores_on_line();
    run_access(1'b1, 32'h0000_0101, dcache_pkg::size_byte, 32'h0000_00ab);
    run_access(1'b1, 32'h0000_0107, dcache_pkg::size_half, 32'h0000_1234);
    run_access(1'b1, 32'h0000_010b, dcache_pkg::size_byte, 32'h5555_55c3);
    run_access(1'b1, 32'h0000_010c, dcache_pkg::size_word, 32'hdead_beef);
    run_access(1'b1, 32'h0000_0108, dcache_pkg::size_half, 32'hffff_7e81);
    for (int a = 'h100; a < 'h110; a += 4) begin
      run_access(1'b0, a, dcache_pkg::size_word, 32'h0);
    end
  endtask

  task automatic write_miss_no_allocate();
    run_access(1'b1, 32'h0000_0230, dcache_pkg::size_word, 32'h0badf00d);
    run_access(1'b0, 32'h0000_0230, dcache_pkg::size_word, 32'h0);
  endtask

  task automatic conflict_eviction();
    int unsigned misses_before;
    misses_before = read_misses;
    for (int i = 0; i < 3; i++) begin
      run_access(1'b0, 32'h0000_0354, dcache_pkg::size_word, 32'h0);
      run_access(1'b0, 32'h0000_0758, dcache_pkg::size_word, 32'h0);
    end
    check_value("conflict read misses", read_misses - misses_before, 6);
  endtask

  task automatic random_mix();
    logic [31:0]              r;
    logic [31:0]              addr;
    logic [31:0]              data;
    dcache_pkg::dcache_size_e size;
    for (int i = 0; i < 200; i++) begin
      op_rng = lcg_step(op_rng);
      r      = op_rng;
      op_rng = lcg_step(op_rng);
      data   = op_rng;
      // Four tags over four indices
      addr = {20'd0, r[31:30], 4'd0, r[29:28], r[27:26], r[25:24]};
      case (r[23:22])
        2'd0:    size = dcache_pkg::size_byte;
        2'd1:    size = dcache_pkg::size_half;
        default: size = dcache_pkg::size_word;
      endcase
      if (size == dcache_pkg::size_half) addr[0] = 1'b0;
      if (size == dcache_pkg::size_word) addr[1:0] = 2'b00;
      run_access(r[21], addr, size, data);
    end
  endtask

  // ==========================================================================
  // Clock, memory stalls, watchdog and main sequence
  // ==========================================================================
  always #2 clk = ~clk;

  always @(posedge clk) begin
    #1;
    stall_rng = lcg_step(stall_rng);
    stall     = (stall_rng[31:29] < 3'd3);
  end

  initial begin
    #(20 + NUM_OPS * OP_BOUND);
    abort_run("Timeout: the cache did not finish all accesses in time");
  end

  initial begin
    clk        = 1'b0;
    rstn       = 1'b0;
    core_req   = 1'b0;
    core_addr  = '0;
    core_write = 1'b0;
    core_size  = dcache_pkg::size_word;
    core_wdata = '0;
    stall      = 1'b0;
    op_rng     = 32'hbdaf149f;
    stall_rng  = lcg_step(32'hbdaf149f);
    exp_rh     = 0;
    exp_wh     = 0;
    exp_rm     = 0;
    exp_wm     = 0;
    for (int i = 0; i < MEM_WORDS; i++) begin
      ref_mem[i]     = fill_word(i * 4);
      u_mem.words[i] = fill_word(i * 4);
    end
    for (int i = 0; i < `DC_LINES; i++) begin
      shadow_valid[i] = 1'b0;
      shadow_tag[i]   = '0;
    end
    repeat (3) @(posedge clk);
    #1;
    rstn = 1'b1;
    @(posedge clk);
    #1;
    check_true(!core_wait, "core_wait is high after reset");
    check_true(!mem_req && !mem_write, "memory request is active after reset");

    cold_miss_then_hit();
    partial_stores_on_line();
    write_miss_no_allocate();
    conflict_eviction();
    random_mix();

    $display("NO ERRORS");
    $finish;
  end

endmodule
